// File: include/blend_cfg.svh
`ifndef BLEND_CFG_SVH
`define BLEND_CFG_SVH

// bits per colour channel.
`define BLEND_CHN_WIDTH 8

// channels per pixel, rgb.
`define BLEND_CHN_NUM 3

// rows, columns and window sizes.
`define BLEND_COORD_WIDTH 12

// register address width.
`define BLEND_REG_ADDR_WIDTH 3

`endif

// File: project.f
+incdir+include
verilog/blend_pkg.sv
verilog/stream_relay.sv
verilog/overlay_regs.sv
verilog/window_tracker.sv
verilog/pixel_blender.sv
verilog/overlay_top.sv
verification/tb_overlay.sv

// File: verification/overlay_vectors.txt
# name frame_w frame_h left top win_w win_h alpha enable stall_base stall_ovl stall_sink
# decimal values; every window lies inside its frame.
bypass_plain 8 6 2 1 3 2 128 0 0 0 0
bypass_stall 10 5 0 0 4 4 200 0 1 1 1
center_half 12 8 3 2 5 4 128 1 0 0 0
alpha_zero 8 8 2 2 4 3 0 1 0 0 0
alpha_full 8 8 2 2 4 3 255 1 0 0 0
alpha_low 8 8 1 3 6 2 1 1 0 0 0
corner_top_left 9 7 0 0 3 3 100 1 0 0 0
corner_bottom_right 9 7 6 4 3 3 77 1 0 0 0
corner_top_right 9 7 5 0 4 2 190 1 0 0 0
corner_bottom_left 9 7 0 5 2 2 33 1 0 0 0
full_frame 6 4 0 0 6 4 160 1 0 0 0
single_pixel 5 5 4 4 1 1 220 1 0 0 0
single_column 1 6 0 2 1 3 140 1 0 0 0
single_row 16 1 5 0 7 1 64 1 0 0 0
stall_base 12 8 4 3 5 3 90 1 1 0 0
stall_overlay 12 8 4 3 5 3 90 1 0 1 0
stall_sink 12 8 4 3 5 3 90 1 0 0 1
stall_all 16 10 2 1 9 7 180 1 1 1 1
stall_all_full 20 6 0 0 20 6 45 1 1 1 1
# window moves between frames of the same size.
move_a 10 8 1 1 4 3 128 1 0 0 0
move_b 10 8 5 4 4 3 128 1 0 0 0
move_off 10 8 5 4 4 3 128 0 0 0 0
move_back 10 8 0 0 2 2 250 1 1 1 1
wide_rows 32 4 10 1 12 2 111 1 1 0 1
right_edge_column 12 6 11 0 1 6 200 1 0 1 1
ramp_repeat_a 8 4 2 1 3 2 70 1 0 1 0
ramp_repeat_b 8 4 2 1 3 2 70 1 0 1 0

// File: verification/tb_overlay.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module tb_overlay
	import blend_pkg::*;
();

	logic clk;
	logic resetn;
	logic cfg_we;
	reg_addr_t cfg_addr;
	coord_t cfg_wdata;
	logic base_valid;
	stream_beat_t base_beat;
	logic base_ready;
	logic ovl_valid;
	stream_beat_t ovl_beat;
	logic ovl_ready;
	logic m_valid;
	stream_beat_t m_beat;
	logic m_ready;

	integer seed;
	string test_name;
	int frame_w, frame_h, win_left, win_top, win_w, win_h;
	int alpha_v, enable_v, stall_base, stall_ovl, stall_sink;
	int wait_limit;
	int out_total = 0;
	int ovl_total = 0;

	overlay_top i_dut (
		.clk        (clk),
		.resetn     (resetn),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.base_valid (base_valid),
		.base_beat  (base_beat),
		.base_ready (base_ready),
		.ovl_valid  (ovl_valid),
		.ovl_beat   (ovl_beat),
		.ovl_ready  (ovl_ready),
		.m_valid    (m_valid),
		.m_beat     (m_beat),
		.m_ready    (m_ready)
	);

	always #10 clk = ~clk;

	// running totals of output beats and overlay beats the blender took.
	always @(posedge clk) begin
		if (resetn && m_valid && m_ready)
			out_total <= out_total + 1;
		if (resetn && i_dut.rel_valid && i_dut.rel_ready)
			ovl_total <= ovl_total + 1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_pixel(input string what, input pixel_t exp, input pixel_t act);
		if (exp !== act)
			abort_run($sformatf("Error: %s %s expected %h actual %h", test_name, what, exp, act));
	endtask

	task automatic check_flags(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act)
			abort_run($sformatf("Error: %s %s expected %b actual %b", test_name, what, exp, act));
	endtask

	task automatic check_count(input string what, input coord_t exp, input coord_t act);
		if (exp !== act)
			abort_run($sformatf("Error: %s %s expected %0d actual %0d", test_name, what, exp, act));
	endtask

	function automatic logic take_stall(input int flag);
		if (flag == 0)
			return 1'b0;
		return ($random(seed) & 3) == 0;
	endfunction

	// channel 0 row, channel 1 column, channel 2 row xor column.
	function automatic pixel_t base_pixel(input int r, input int c);
		chan_t ch_row;
		chan_t ch_col;
		chan_t ch_mix;
		ch_row = r;
		ch_col = c;
		ch_mix = r ^ c;
		return {ch_mix, ch_col, ch_row};
	endfunction

	function automatic pixel_t ovl_pixel(input int k);
		chan_t ch0;
		chan_t ch1;
		chan_t ch2;
		ch0 = k * 3 + 1;
		ch1 = k * 5 + 7;
		ch2 = 255 - k;
		return {ch2, ch1, ch0};
	endfunction

	// weighted sum, keep the upper channel bits.
	function automatic chan_t mix_chan(input int b, input int o, input int a);
		int acc;
		chan_t res;
		acc = o * a + b * ((1 << `BLEND_CHN_WIDTH) - a);
		res = acc >> `BLEND_CHN_WIDTH;
		return res;
	endfunction

	function automatic pixel_t expect_pixel(input int r, input int c);
		pixel_t b;
		pixel_t o;
		pixel_t res;
		int k;
		b = base_pixel(r, c);
		if (enable_v == 0 || r < win_top || r >= win_top + win_h || c < win_left ||
			c >= win_left + win_w)
			return b;
		k = (r - win_top) * win_w + (c - win_left);
		o = ovl_pixel(k);
		for (int i = 0; i < `BLEND_CHN_NUM; i++) begin
			res[i*`BLEND_CHN_WIDTH +: `BLEND_CHN_WIDTH] = mix_chan(
				b[i*`BLEND_CHN_WIDTH +: `BLEND_CHN_WIDTH],
				o[i*`BLEND_CHN_WIDTH +: `BLEND_CHN_WIDTH], alpha_v);
		end
		return res;
	endfunction

	task automatic write_reg(input reg_sel_e sel, input int value);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = sel;
		cfg_wdata = value[`BLEND_COORD_WIDTH-1:0];
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic send_base();
		int idx;
		int idle;
		logic holding;
		idx = 0;
		idle = 0;
		holding = 1'b0;
		while (idx < frame_w * frame_h) begin
			@(negedge clk);
			if (!holding) begin
				base_valid = 1'b0;
				if (!take_stall(stall_base)) begin
					base_beat.data = base_pixel(idx / frame_w, idx % frame_w);
					base_beat.sof = (idx == 0);
					base_beat.last = (idx % frame_w == frame_w - 1);
					base_valid = 1'b1;
					holding = 1'b1;
				end
			end
			@(posedge clk);
			if (base_valid && base_ready) begin
				idx++;
				holding = 1'b0;
				idle = 0;
			end else if (++idle > wait_limit) begin
				abort_run($sformatf("Timeout: base stream not accepted in test %s", test_name));
			end
		end
		@(negedge clk);
		base_valid = 1'b0;
	endtask

	// exactly one overlay beat per window pixel, ramp restarts per frame.
	task automatic send_ovl(input int count);
		int k;
		int idle;
		logic holding;
		k = 0;
		idle = 0;
		holding = 1'b0;
		while (k < count) begin
			@(negedge clk);
			if (!holding) begin
				ovl_valid = 1'b0;
				if (!take_stall(stall_ovl)) begin
					ovl_beat.data = ovl_pixel(k);
					ovl_beat.sof = (k == 0);
					ovl_beat.last = (k % win_w == win_w - 1);
					ovl_valid = 1'b1;
					holding = 1'b1;
				end
			end
			@(posedge clk);
			if (ovl_valid && ovl_ready) begin
				k++;
				holding = 1'b0;
				idle = 0;
			end else if (++idle > wait_limit) begin
				abort_run($sformatf("Timeout: overlay stream not accepted in test %s",
					test_name));
			end
		end
		@(negedge clk);
		ovl_valid = 1'b0;
	endtask

	task automatic collect_out();
		int idx;
		int idle;
		int r;
		int c;
		idx = 0;
		idle = 0;
		while (idx < frame_w * frame_h) begin
			@(negedge clk);
			m_ready = !take_stall(stall_sink);
			@(posedge clk);
			if (m_valid && m_ready) begin
				r = idx / frame_w;
				c = idx % frame_w;
				check_pixel($sformatf("pixel %0d,%0d", r, c), expect_pixel(r, c), m_beat.data);
				check_flags($sformatf("sof,last %0d,%0d", r, c), {idx == 0, c == frame_w - 1},
					{m_beat.sof, m_beat.last});
				idx++;
				idle = 0;
			end else if (++idle > wait_limit) begin
				abort_run($sformatf("Timeout: no output beat in test %s", test_name));
			end
		end
		@(negedge clk);
		m_ready = 1'b1;
	endtask

	task automatic run_test();
		int out_start;
		int ovl_start;
		int ovl_count;
		ovl_count = (enable_v != 0) ? win_w * win_h : 0;
		wait_limit = 20 * frame_w * frame_h + 100;
		write_reg(REG_LEFT, win_left);
		write_reg(REG_TOP, win_top);
		write_reg(REG_WIDTH, win_w);
		write_reg(REG_HEIGHT, win_h);
		write_reg(REG_ALPHA, alpha_v);
		write_reg(REG_ENABLE, enable_v);
		@(negedge clk);
		out_start = out_total;
		ovl_start = ovl_total;
		fork
			send_base();
			send_ovl(ovl_count);
			collect_out();
		join
		// idle gap, no stray beats may follow.
		repeat (4) @(negedge clk);
		check_count("output beats", frame_w * frame_h, out_total - out_start);
		check_count("overlay beats", ovl_count, ovl_total - ovl_start);
		$display("test %s done", test_name);
	endtask

	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	initial begin
		int fd;
		int code;
		int tests_run;
		seed = 32793;
		tests_run = 0;
		clk = 1'b0;
		resetn = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		base_valid = 1'b0;
		base_beat = '0;
		ovl_valid = 1'b0;
		ovl_beat = '0;
		m_ready = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		m_ready = 1'b1;
		repeat (2) @(negedge clk);
		fd = $fopen("verification/overlay_vectors.txt", "r");
		if (fd == 0)
			abort_run("Could not open verification/overlay_vectors.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", test_name);
			if (code == 1 && test_name[0] == "#") begin
				skip_line(fd);
			end else if (code == 1) begin
				code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d", frame_w, frame_h,
					win_left, win_top, win_w, win_h, alpha_v, enable_v,
					stall_base, stall_ovl, stall_sink);
				if (code != 11)
					abort_run($sformatf("Malformed vector line for test %s", test_name));
				run_test();
				tests_run++;
			end
		end
		$fclose(fd);
		if (tests_run == 0)
			abort_run("The vector file held no tests");
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/blend_pkg.sv
`default_nettype none

`include "blend_cfg.svh"

package blend_pkg;

	typedef logic [`BLEND_CHN_WIDTH-1:0] chan_t;
	typedef logic [`BLEND_CHN_NUM*`BLEND_CHN_WIDTH-1:0] pixel_t;
	typedef logic [`BLEND_COORD_WIDTH-1:0] coord_t;
	typedef logic [`BLEND_CHN_WIDTH-1:0] alpha_t;
	typedef logic [`BLEND_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// one beat of a pixel stream, valid and ready travel beside it.
	typedef struct packed {
		pixel_t data;
		logic sof;
		logic last;
	} stream_beat_t;

	typedef enum reg_addr_t {
		REG_LEFT   = 3'd0,
		REG_TOP    = 3'd1,
		REG_WIDTH  = 3'd2,
		REG_HEIGHT = 3'd3,
		REG_ALPHA  = 3'd4,
		REG_ENABLE = 3'd5
	} reg_sel_e;

	typedef struct packed {
		coord_t left;
		coord_t top;
		coord_t width;
		coord_t height;
		alpha_t alpha;
		logic enable;
	} win_cfg_t;

endpackage

`default_nettype wire

// File: verilog/overlay_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module overlay_regs
	import blend_pkg::*;
(
	input wire clk,
	input wire resetn,

	input wire cfg_we,
	input wire reg_addr_t cfg_addr,
	input wire coord_t cfg_wdata,

	input wire frame_done,
	output win_cfg_t win_cfg
);

	win_cfg_t pending;
	win_cfg_t active;

	// writes land in the pending copy only.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pending <= '0;
		end else if (cfg_we) begin
			case (reg_sel_e'(cfg_addr))
				REG_LEFT:   pending.left <= cfg_wdata;
				REG_TOP:    pending.top <= cfg_wdata;
				REG_WIDTH:  pending.width <= cfg_wdata;
				REG_HEIGHT: pending.height <= cfg_wdata;
				REG_ALPHA:  pending.alpha <= cfg_wdata[$bits(alpha_t)-1:0];
				REG_ENABLE: pending.enable <= cfg_wdata[0];
				default:    ;
			endcase
		end
	end

	// swap at the frame boundary.
	always_ff @(posedge clk) begin
		if (!resetn || frame_done)
			active <= pending;
	end

	// the first pixel of a frame already sees the new window.
	assign win_cfg = frame_done ? pending : active;

endmodule

`default_nettype wire

// File: verilog/overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module overlay_top
	import blend_pkg::*;
(
	input wire clk,
	input wire resetn,

	input wire cfg_we,
	input wire reg_addr_t cfg_addr,
	input wire coord_t cfg_wdata,

	input wire base_valid,
	input wire stream_beat_t base_beat,
	output logic base_ready,

	input wire ovl_valid,
	input wire stream_beat_t ovl_beat,
	output logic ovl_ready,

	output logic m_valid,
	output stream_beat_t m_beat,
	input wire m_ready
);

	win_cfg_t win_cfg;
	logic frame_done;
	logic in_window;
	logic base_fire;
	logic base_sof;
	logic base_last;
	logic rel_valid;
	stream_beat_t rel_beat;
	logic rel_ready;

	overlay_regs i_regs (
		.clk        (clk),
		.resetn     (resetn),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.frame_done (frame_done),
		.win_cfg    (win_cfg)
	);

	// overlay side gets a registered ready.
	stream_relay i_relay (
		.clk     (clk),
		.resetn  (resetn),
		.s_valid (ovl_valid),
		.s_beat  (ovl_beat),
		.s_ready (ovl_ready),
		.m_valid (rel_valid),
		.m_beat  (rel_beat),
		.m_ready (rel_ready)
	);

	window_tracker i_tracker (
		.clk        (clk),
		.resetn     (resetn),
		.base_fire  (base_fire),
		.base_sof   (base_sof),
		.base_last  (base_last),
		.win_cfg    (win_cfg),
		.in_window  (in_window),
		.frame_done (frame_done)
	);

	pixel_blender i_blender (
		.clk        (clk),
		.resetn     (resetn),
		.base_valid (base_valid),
		.base_beat  (base_beat),
		.base_ready (base_ready),
		.rel_valid  (rel_valid),
		.rel_beat   (rel_beat),
		.rel_ready  (rel_ready),
		.in_window  (in_window),
		.win_cfg    (win_cfg),
		.base_fire  (base_fire),
		.base_sof   (base_sof),
		.base_last  (base_last),
		.m_valid    (m_valid),
		.m_beat     (m_beat),
		.m_ready    (m_ready)
	);

endmodule

`default_nettype wire

// File: verilog/pixel_blender.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module pixel_blender
	import blend_pkg::*;
(
	input wire clk,
	input wire resetn,

	input wire base_valid,
	input wire stream_beat_t base_beat,
	output logic base_ready,

	input wire rel_valid,
	input wire stream_beat_t rel_beat,
	output logic rel_ready,

	input wire in_window,
	input wire win_cfg_t win_cfg,

	output logic base_fire,
	output logic base_sof,
	output logic base_last,

	output logic m_valid,
	output stream_beat_t m_beat,
	input wire m_ready
);

	localparam int CW = `BLEND_CHN_WIDTH;
	localparam int CN = `BLEND_CHN_NUM;

	logic run;
	logic use_ovl;
	logic slot_free;
	pixel_t mix_pix;

	// out = (ovl * a + base * (256 - a)) >> 8.
	function automatic chan_t blend_chan(input chan_t b, input chan_t o, input alpha_t a);
		logic [CW:0] inv;
		logic [2*CW:0] acc;
		inv = (CW+1)'(1 << CW) - a;
		acc = o * a + b * inv;
		return acc[2*CW-1:CW];
	endfunction

	// inputs held off until reset is released.
	always_ff @(posedge clk) begin
		if (!resetn)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	assign use_ovl = in_window && win_cfg.enable;
	assign slot_free = !m_valid || m_ready;

	// an in-window base pixel waits for its overlay partner.
	assign base_ready = run && slot_free && (!use_ovl || rel_valid);
	assign rel_ready = base_valid && base_ready && use_ovl;

	assign base_fire = base_valid && base_ready;
	assign base_sof = base_valid && base_beat.sof;
	assign base_last = base_beat.last;

	always_comb begin
		mix_pix = base_beat.data;
		if (use_ovl) begin
			for (int c = 0; c < CN; c++) begin
				mix_pix[c*CW +: CW] = blend_chan(base_beat.data[c*CW +: CW],
					rel_beat.data[c*CW +: CW], win_cfg.alpha);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			m_valid <= 1'b0;
		else if (slot_free)
			m_valid <= base_fire;
	end

	always_ff @(posedge clk) begin
		if (base_fire) begin
			m_beat.data <= mix_pix;
			m_beat.sof <= base_beat.sof;
			m_beat.last <= base_beat.last;
		end
	end

	// a base pixel held back for its overlay partner must not change.
	a_base_hold: assert property (@(posedge clk) disable iff (!resetn)
		base_valid && !base_ready |=> base_valid && $stable(base_beat));

	a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

// File: verilog/stream_relay.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module stream_relay
	import blend_pkg::*;
(
	input wire clk,
	input wire resetn,

	input wire s_valid,
	input wire stream_beat_t s_beat,
	output logic s_ready,

	output logic m_valid,
	output stream_beat_t m_beat,
	input wire m_ready
);

	stream_beat_t skid_beat;
	logic skid_valid;
	logic s_fire;
	logic main_free;
	logic main_load;
	logic main_from_skid;
	logic skid_load;
	logic main_valid_d;
	logic skid_valid_d;

	assign s_fire = s_valid && s_ready;
	assign main_free = !m_valid || m_ready;

	// the skid slot fills only while the main slot is held.
	always_comb begin
		main_valid_d = m_valid;
		skid_valid_d = skid_valid;
		main_load = 1'b0;
		main_from_skid = 1'b0;
		skid_load = 1'b0;
		if (main_free) begin
			if (skid_valid) begin
				main_load = 1'b1;
				main_from_skid = 1'b1;
				main_valid_d = 1'b1;
				skid_valid_d = 1'b0;
			end else begin
				main_load = s_fire;
				main_valid_d = s_fire;
			end
		end else if (s_fire) begin
			skid_load = 1'b1;
			skid_valid_d = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_valid <= 1'b0;
			skid_valid <= 1'b0;
			s_ready <= 1'b0;
		end else begin
			m_valid <= main_valid_d;
			skid_valid <= skid_valid_d;
			s_ready <= !skid_valid_d;
		end
	end

	always_ff @(posedge clk) begin
		if (main_load)
			m_beat <= main_from_skid ? skid_beat : s_beat;
		if (skid_load)
			skid_beat <= s_beat;
	end

	a_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

// File: verilog/window_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module window_tracker
	import blend_pkg::*;
(
	input wire clk,
	input wire resetn,

	input wire base_fire,
	input wire base_sof,
	input wire base_last,

	input wire win_cfg_t win_cfg,
	output logic in_window,
	output logic frame_done
);

	coord_t row;
	coord_t col;
	coord_t cur_row;
	coord_t cur_col;
	logic [`BLEND_COORD_WIDTH:0] row_end;
	logic [`BLEND_COORD_WIDTH:0] col_end;
	logic row_hit;
	logic col_hit;

	// a sof beat is row 0, column 0 whatever the counters hold.
	assign cur_row = base_sof ? '0 : row;
	assign cur_col = base_sof ? '0 : col;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row <= '0;
			col <= '0;
		end else if (base_fire) begin
			if (base_last) begin
				row <= cur_row + 1'b1;
				col <= '0;
			end else begin
				row <= cur_row;
				col <= cur_col + 1'b1;
			end
		end
	end

	// one extra bit so top plus height cannot wrap.
	assign row_end = {1'b0, win_cfg.top} + {1'b0, win_cfg.height};
	assign col_end = {1'b0, win_cfg.left} + {1'b0, win_cfg.width};

	assign row_hit = (cur_row >= win_cfg.top) && ({1'b0, cur_row} < row_end);
	assign col_hit = (cur_col >= win_cfg.left) && ({1'b0, cur_col} < col_end);

	assign in_window = win_cfg.enable && row_hit && col_hit;

	// high while a sof beat waits, so the new window is in place for it.
	assign frame_done = base_sof;

	a_col_range: assert property (@(posedge clk) disable iff (!resetn)
		col != '1);

endmodule

`default_nettype wire
